// File: logic/lc4_isa_pkg.sv
package lc4_isa_pkg;

  // Raw instruction word as fetched from instruction memory
  typedef logic [15:0] insn_t;

  // Bits 15:12 of every instruction
  typedef logic [3:0] opcode_t;

  // Supported opcodes, anything else decodes to a NOP
  localparam opcode_t OP_BR    = 4'b0000; // NZP mask in 11:9, imm9 offset from PC+1
  localparam opcode_t OP_ARITH = 4'b0001; // ADD/SUB by register, ADD imm5
  localparam opcode_t OP_LOGIC = 4'b0101; // AND by register only
  localparam opcode_t OP_LDR   = 4'b0110; // Rd <= mem[Rs + imm6]
  localparam opcode_t OP_STR   = 4'b0111; // mem[Rs + imm6] <= Rt
  localparam opcode_t OP_CONST = 4'b1001; // Rd <= sext(imm9)

  // Arith sub-op field, bits 5:3
  localparam logic [2:0] SUB_ADD = 3'b000;
  localparam logic [2:0] SUB_SUB = 3'b010;

  // Immediate field widths, all fields start at bit 0
  localparam int IMM9_W = 9;
  localparam int IMM6_W = 6;
  localparam int IMM5_W = 5; // Also the position of the arith immediate flag

  // BR with empty mask, never taken and writes nothing
  localparam insn_t NOP_INSN = 16'h0000;

  // ALU function picked in decode
  typedef logic [2:0] alu_op_t;

  localparam alu_op_t ALU_ADD   = 3'd0; // A + B, also address calc for LDR/STR
  localparam alu_op_t ALU_SUB   = 3'd1;
  localparam alu_op_t ALU_AND   = 3'd2;
  localparam alu_op_t ALU_PASSB = 3'd3; // CONST
  localparam alu_op_t ALU_ADDPC = 3'd4; // PC + 1 + B, branch target

endpackage

// File: logic/lc4_pipe_pkg.sv
package lc4_pipe_pkg;

  // Datapath value or address
  typedef logic [15:0] word_t;

  // R0 to R7
  typedef logic [2:0] reg_idx_t;

  // Condition flags, N in bit 2, Z in bit 1, P in bit 0
  typedef logic [2:0] nzp_t;

  // Flags a register write would set for value v
  function automatic nzp_t nzp_of(input word_t v);
    logic is_zero;
    is_zero = (v == '0);
    return {v[15], is_zero, !v[15] && !is_zero};
  endfunction

endpackage

// File: logic/lc4_fetch.sv
module lc4_fetch #(
  parameter lc4_pipe_pkg::word_t P_RESET_PC = 16'h8200
) (
  input  logic                gwe,
  input  logic                i_rst_n,
  input  logic                i_redirect,  // Taken branch from execute
  input  lc4_pipe_pkg::word_t i_target,
  input  lc4_isa_pkg::insn_t  i_imem_data,
  output lc4_pipe_pkg::word_t o_imem_addr,
  output lc4_pipe_pkg::word_t o_d_pc,
  output lc4_isa_pkg::insn_t  o_d_insn
);
  import lc4_isa_pkg::*;
  import lc4_pipe_pkg::*;

  word_t pc_q;
  word_t next_pc;

  // Redirect wins over sequential fetch
  assign next_pc     = i_redirect ? i_target : pc_q + 16'd1;
  assign o_imem_addr = pc_q;

  always_ff @(posedge gwe or negedge i_rst_n) begin
    if (!i_rst_n) begin
      pc_q     <= P_RESET_PC;
      o_d_insn <= NOP_INSN;
    end else begin
      pc_q <= next_pc;
      // Word fetched under a taken branch is wrong path and gets squashed
      o_d_insn <= i_redirect ? NOP_INSN : i_imem_data;
    end
  end

  // PC of the word now in decode
  always_ff @(posedge gwe) begin
    o_d_pc <= pc_q;
  end

endmodule

// File: logic/lc4_regfile.sv
module lc4_regfile (
  input  logic                   gwe,
  input  logic                   i_rst_n,
  input  lc4_pipe_pkg::reg_idx_t i_rs_sel,
  input  lc4_pipe_pkg::reg_idx_t i_rt_sel,
  input  logic                   i_we,
  input  lc4_pipe_pkg::reg_idx_t i_wsel,
  input  lc4_pipe_pkg::word_t    i_wdata,
  output lc4_pipe_pkg::word_t    o_rs_data,
  output lc4_pipe_pkg::word_t    o_rt_data
);
  import lc4_pipe_pkg::*;

  word_t regs [8]; // R0..R7

  always_ff @(posedge gwe or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 0; i < 8; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we) begin
      regs[i_wsel] <= i_wdata; // Visible to readers next cycle
    end
  end

  // Async read, same-cycle write is covered by the decode bypass
  assign o_rs_data = regs[i_rs_sel];
  assign o_rt_data = regs[i_rt_sel];

endmodule

// File: logic/lc4_decode.sv
module lc4_decode (
  input  logic                   gwe,
  input  logic                   i_rst_n,
  input  lc4_pipe_pkg::word_t    i_pc,
  input  lc4_isa_pkg::insn_t     i_insn,
  input  logic                   i_squash,    // Taken branch in execute
  input  logic                   i_w_we,      // Writeback bus
  input  lc4_pipe_pkg::reg_idx_t i_w_sel,
  input  lc4_pipe_pkg::word_t    i_w_data,
  output lc4_pipe_pkg::word_t    o_x_pc,
  output lc4_isa_pkg::insn_t     o_x_insn,
  output lc4_isa_pkg::alu_op_t   o_x_alu_op,
  output lc4_pipe_pkg::reg_idx_t o_x_rs_sel,
  output lc4_pipe_pkg::reg_idx_t o_x_rt_sel,
  output lc4_pipe_pkg::word_t    o_x_rs_data,
  output lc4_pipe_pkg::word_t    o_x_rt_data,
  output lc4_pipe_pkg::reg_idx_t o_x_wsel,
  output logic                   o_x_we,
  output logic                   o_x_nzp_we,
  output logic                   o_x_is_load,
  output logic                   o_x_is_store,
  output logic                   o_x_is_branch
);
  import lc4_isa_pkg::*;
  import lc4_pipe_pkg::*;

  opcode_t  opcode;
  alu_op_t  alu_op;
  reg_idx_t rs_sel;
  reg_idx_t rt_sel;
  reg_idx_t wsel;
  logic     we;
  logic     is_load;
  logic     is_store;
  logic     is_branch;
  word_t    rf_rs;
  word_t    rf_rt;
  word_t    rs_data;
  word_t    rt_data;

  assign opcode = i_insn[15:12];
  assign rs_sel = i_insn[8:6];  // Source A, or base for LDR/STR
  assign wsel   = i_insn[11:9];
  // STR carries its data register where others have Rd
  assign rt_sel = (opcode == OP_STR) ? i_insn[11:9] : i_insn[2:0];

  always_comb begin
    alu_op    = ALU_ADD;
    we        = 1'b0;
    is_load   = 1'b0;
    is_store  = 1'b0;
    is_branch = 1'b0;
    case (opcode)
      OP_BR: begin
        alu_op    = ALU_ADDPC; // Target computed in execute
        is_branch = 1'b1;
      end
      OP_ARITH: begin
        if (i_insn[IMM5_W]) begin
          we = 1'b1;           // ADD imm5
        end else if (i_insn[5:3] == SUB_ADD) begin
          we = 1'b1;
        end else if (i_insn[5:3] == SUB_SUB) begin
          alu_op = ALU_SUB;
          we     = 1'b1;
        end
      end
      OP_LOGIC: begin
        if (i_insn[5:3] == 3'b000) begin // AND is the only logic op kept
          alu_op = ALU_AND;
          we     = 1'b1;
        end
      end
      OP_LDR: begin
        we      = 1'b1;
        is_load = 1'b1;
      end
      OP_STR:   is_store = 1'b1;
      OP_CONST: begin
        alu_op = ALU_PASSB;
        we     = 1'b1;
      end
      default: ; // Unsupported word, behaves as NOP
    endcase
  end

  lc4_regfile u_regfile (
    .gwe       (gwe),
    .i_rst_n   (i_rst_n),
    .i_rs_sel  (rs_sel),
    .i_rt_sel  (rt_sel),
    .i_we      (i_w_we),
    .i_wsel    (i_w_sel),
    .i_wdata   (i_w_data),
    .o_rs_data (rf_rs),
    .o_rt_data (rf_rt)
  );

  // Regfile updates at the edge, so take the writeback value directly
  assign rs_data = (i_w_we && i_w_sel == rs_sel) ? i_w_data : rf_rs;
  assign rt_data = (i_w_we && i_w_sel == rt_sel) ? i_w_data : rf_rt;

  always_ff @(posedge gwe or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_x_insn      <= NOP_INSN;
      o_x_alu_op    <= ALU_ADD;
      o_x_we        <= 1'b0;
      o_x_nzp_we    <= 1'b0;
      o_x_is_load   <= 1'b0;
      o_x_is_store  <= 1'b0;
      o_x_is_branch <= 1'b0;
    end else begin
      o_x_insn      <= i_squash ? NOP_INSN : i_insn;
      o_x_alu_op    <= alu_op;
      o_x_we        <= we && !i_squash;
      o_x_nzp_we    <= we && !i_squash; // Every register write sets flags
      o_x_is_load   <= is_load && !i_squash;
      o_x_is_store  <= is_store && !i_squash;
      o_x_is_branch <= is_branch && !i_squash;
    end
  end

  always_ff @(posedge gwe) begin
    o_x_pc      <= i_pc;
    o_x_rs_sel  <= rs_sel;
    o_x_rt_sel  <= rt_sel;
    o_x_rs_data <= rs_data;
    o_x_rt_data <= rt_data;
    o_x_wsel    <= wsel;
  end

endmodule

// File: logic/lc4_execute.sv
module lc4_execute (
  input  logic                   gwe,
  input  logic                   i_rst_n,
  input  lc4_pipe_pkg::word_t    i_pc,
  input  lc4_isa_pkg::insn_t     i_insn,
  input  lc4_isa_pkg::alu_op_t   i_alu_op,
  input  lc4_pipe_pkg::reg_idx_t i_rs_sel,
  input  lc4_pipe_pkg::reg_idx_t i_rt_sel,
  input  lc4_pipe_pkg::word_t    i_rs_data,
  input  lc4_pipe_pkg::word_t    i_rt_data,
  input  lc4_pipe_pkg::reg_idx_t i_wsel,
  input  logic                   i_we,
  input  logic                   i_nzp_we,
  input  logic                   i_is_load,
  input  logic                   i_is_store,
  input  logic                   i_is_branch,
  input  logic                   i_m_we,      // Memory stage, first bypass source
  input  lc4_pipe_pkg::reg_idx_t i_m_sel,
  input  lc4_pipe_pkg::word_t    i_m_result,
  input  logic                   i_m_nzp_we,
  input  lc4_pipe_pkg::nzp_t     i_m_nzp,
  input  logic                   i_w_we,      // Writeback stage, second source
  input  lc4_pipe_pkg::reg_idx_t i_w_sel,
  input  lc4_pipe_pkg::word_t    i_w_data,
  input  logic                   i_w_nzp_we,
  input  lc4_pipe_pkg::nzp_t     i_w_nzp,
  input  lc4_pipe_pkg::nzp_t     i_nzp,       // Committed flags
  output logic                   o_redirect,
  output lc4_pipe_pkg::word_t    o_target,
  output lc4_pipe_pkg::word_t    o_m_result,
  output lc4_pipe_pkg::word_t    o_m_wdata,
  output lc4_pipe_pkg::reg_idx_t o_m_wsel,
  output logic                   o_m_we,
  output logic                   o_m_nzp_we,
  output lc4_pipe_pkg::nzp_t     o_m_nzp,
  output logic                   o_m_is_load,
  output logic                   o_m_is_store
);
  import lc4_isa_pkg::*;
  import lc4_pipe_pkg::*;

  word_t rs_val;
  word_t rt_val;
  word_t imm9;
  word_t imm6;
  word_t imm5;
  word_t op_b;
  word_t alu_out;
  nzp_t  cur_nzp;

  // Newest producer wins: memory, then writeback, then decode's read
  assign rs_val = (i_m_we && i_m_sel == i_rs_sel) ? i_m_result :
                  (i_w_we && i_w_sel == i_rs_sel) ? i_w_data : i_rs_data;
  assign rt_val = (i_m_we && i_m_sel == i_rt_sel) ? i_m_result :
                  (i_w_we && i_w_sel == i_rt_sel) ? i_w_data : i_rt_data;

  // Sign-extended immediates
  assign imm9 = {{($bits(word_t) - IMM9_W){i_insn[IMM9_W-1]}}, i_insn[IMM9_W-1:0]};
  assign imm6 = {{($bits(word_t) - IMM6_W){i_insn[IMM6_W-1]}}, i_insn[IMM6_W-1:0]};
  assign imm5 = {{($bits(word_t) - IMM5_W){i_insn[IMM5_W-1]}}, i_insn[IMM5_W-1:0]};

  always_comb begin
    if (i_is_load || i_is_store) begin
      op_b = imm6;                                   // Base + offset
    end else if (i_alu_op == ALU_PASSB || i_alu_op == ALU_ADDPC) begin
      op_b = imm9;                                   // CONST or BR offset
    end else if (i_alu_op == ALU_ADD && i_insn[IMM5_W]) begin
      op_b = imm5;
    end else begin
      op_b = rt_val;
    end
  end

  always_comb begin
    case (i_alu_op)
      ALU_ADD:   alu_out = rs_val + op_b;
      ALU_SUB:   alu_out = rs_val - op_b;
      ALU_AND:   alu_out = rs_val & op_b;
      ALU_PASSB: alu_out = op_b;
      ALU_ADDPC: alu_out = i_pc + 16'd1 + op_b;
      default:   alu_out = op_b;
    endcase
  end

  // Flags seen by a branch, youngest writer first
  assign cur_nzp = i_m_nzp_we ? i_m_nzp :
                   i_w_nzp_we ? i_w_nzp : i_nzp;

  // Taken branch also squashes decode and fetch
  assign o_redirect = i_is_branch && |(i_insn[11:9] & cur_nzp);
  assign o_target   = alu_out;

  always_ff @(posedge gwe or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_m_we       <= 1'b0;
      o_m_nzp_we   <= 1'b0;
      o_m_is_load  <= 1'b0;
      o_m_is_store <= 1'b0;
    end else begin
      o_m_we       <= i_we;
      o_m_nzp_we   <= i_nzp_we;
      o_m_is_load  <= i_is_load;
      o_m_is_store <= i_is_store;
    end
  end

  always_ff @(posedge gwe) begin
    o_m_result <= alu_out;         // Address for LDR/STR
    o_m_wdata  <= rt_val;          // Store data
    o_m_wsel   <= i_wsel;
    o_m_nzp    <= nzp_of(alu_out); // Wrong for loads, fixed in writeback
  end

endmodule

// File: logic/lc4_memory.sv
module lc4_memory (
  input  logic                   gwe,
  input  logic                   i_rst_n,
  input  lc4_pipe_pkg::word_t    i_m_result,
  input  lc4_pipe_pkg::word_t    i_m_wdata,
  input  lc4_pipe_pkg::reg_idx_t i_m_wsel,
  input  logic                   i_m_we,
  input  logic                   i_m_nzp_we,
  input  lc4_pipe_pkg::nzp_t     i_m_nzp,
  input  logic                   i_m_is_load,
  input  logic                   i_m_is_store,
  input  lc4_pipe_pkg::word_t    i_dmem_rdata,
  output lc4_pipe_pkg::word_t    o_dmem_addr,
  output logic                   o_dmem_we,
  output lc4_pipe_pkg::word_t    o_dmem_wdata,
  output logic                   o_w_we,
  output lc4_pipe_pkg::reg_idx_t o_w_sel,
  output lc4_pipe_pkg::word_t    o_w_data,
  output logic                   o_w_nzp_we,
  output lc4_pipe_pkg::nzp_t     o_w_nzp,
  output lc4_pipe_pkg::nzp_t     o_nzp
);
  import lc4_pipe_pkg::*;

  logic  w_is_load;
  word_t w_alu;
  word_t w_rdata;
  nzp_t  w_nzp;
  nzp_t  nzp_q;

  // Data memory answers in the same cycle
  assign o_dmem_addr  = i_m_result;
  assign o_dmem_we    = i_m_is_store;
  assign o_dmem_wdata = i_m_wdata;

  always_ff @(posedge gwe or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_w_we     <= 1'b0;
      o_w_nzp_we <= 1'b0;
      w_is_load  <= 1'b0;
    end else begin
      o_w_we     <= i_m_we;
      o_w_nzp_we <= i_m_nzp_we;
      w_is_load  <= i_m_is_load;
    end
  end

  always_ff @(posedge gwe) begin
    o_w_sel <= i_m_wsel;
    w_alu   <= i_m_result;
    w_rdata <= i_dmem_rdata;
    w_nzp   <= i_m_nzp;
  end

  // Loads take the memory word and flags derived from it
  assign o_w_data = w_is_load ? w_rdata : w_alu;
  assign o_w_nzp  = w_is_load ? nzp_of(w_rdata) : w_nzp;

  // Committed flags, written alongside the register file
  always_ff @(posedge gwe or negedge i_rst_n) begin
    if (!i_rst_n) begin
      nzp_q <= '0;
    end else if (o_w_nzp_we) begin
      nzp_q <= o_w_nzp;
    end
  end

  assign o_nzp = nzp_q;

endmodule

// File: logic/lc4_core.sv
module lc4_core #(
  parameter lc4_pipe_pkg::word_t P_RESET_PC = 16'h8200
) (
  input  logic                gwe,
  input  logic                i_rst_n,
  output lc4_pipe_pkg::word_t o_imem_addr,
  input  lc4_isa_pkg::insn_t  i_imem_data,
  output lc4_pipe_pkg::word_t o_dmem_addr,
  output logic                o_dmem_we,
  output lc4_pipe_pkg::word_t o_dmem_wdata,
  input  lc4_pipe_pkg::word_t i_dmem_rdata
);
  import lc4_isa_pkg::*;
  import lc4_pipe_pkg::*;

  logic     redirect;   // Also the decode squash
  word_t    target;
  word_t    d_pc;
  insn_t    d_insn;
  word_t    x_pc;
  insn_t    x_insn;
  alu_op_t  x_alu_op;
  reg_idx_t x_rs_sel;
  reg_idx_t x_rt_sel;
  word_t    x_rs_data;
  word_t    x_rt_data;
  reg_idx_t x_wsel;
  logic     x_we;
  logic     x_nzp_we;
  logic     x_is_load;
  logic     x_is_store;
  logic     x_is_branch;
  word_t    m_result;
  word_t    m_wdata;
  reg_idx_t m_wsel;
  logic     m_we;
  logic     m_nzp_we;
  nzp_t     m_nzp;
  logic     m_is_load;
  logic     m_is_store;
  logic     w_we;       // Writeback bus into regfile and bypasses
  reg_idx_t w_sel;
  word_t    w_data;
  logic     w_nzp_we;
  nzp_t     w_nzp;
  nzp_t     nzp;        // Committed flags

  lc4_fetch #(.P_RESET_PC(P_RESET_PC)) u_fetch (
    .gwe         (gwe),
    .i_rst_n     (i_rst_n),
    .i_redirect  (redirect),
    .i_target    (target),
    .i_imem_data (i_imem_data),
    .o_imem_addr (o_imem_addr),
    .o_d_pc      (d_pc),
    .o_d_insn    (d_insn)
  );

  lc4_decode u_decode (
    .gwe           (gwe),
    .i_rst_n       (i_rst_n),
    .i_pc          (d_pc),
    .i_insn        (d_insn),
    .i_squash      (redirect),
    .i_w_we        (w_we),
    .i_w_sel       (w_sel),
    .i_w_data      (w_data),
    .o_x_pc        (x_pc),
    .o_x_insn      (x_insn),
    .o_x_alu_op    (x_alu_op),
    .o_x_rs_sel    (x_rs_sel),
    .o_x_rt_sel    (x_rt_sel),
    .o_x_rs_data   (x_rs_data),
    .o_x_rt_data   (x_rt_data),
    .o_x_wsel      (x_wsel),
    .o_x_we        (x_we),
    .o_x_nzp_we    (x_nzp_we),
    .o_x_is_load   (x_is_load),
    .o_x_is_store  (x_is_store),
    .o_x_is_branch (x_is_branch)
  );

  lc4_execute u_execute (
    .gwe          (gwe),
    .i_rst_n      (i_rst_n),
    .i_pc         (x_pc),
    .i_insn       (x_insn),
    .i_alu_op     (x_alu_op),
    .i_rs_sel     (x_rs_sel),
    .i_rt_sel     (x_rt_sel),
    .i_rs_data    (x_rs_data),
    .i_rt_data    (x_rt_data),
    .i_wsel       (x_wsel),
    .i_we         (x_we),
    .i_nzp_we     (x_nzp_we),
    .i_is_load    (x_is_load),
    .i_is_store   (x_is_store),
    .i_is_branch  (x_is_branch),
    .i_m_we       (m_we),
    .i_m_sel      (m_wsel),
    .i_m_result   (m_result),
    .i_m_nzp_we   (m_nzp_we),
    .i_m_nzp      (m_nzp),
    .i_w_we       (w_we),
    .i_w_sel      (w_sel),
    .i_w_data     (w_data),
    .i_w_nzp_we   (w_nzp_we),
    .i_w_nzp      (w_nzp),
    .i_nzp        (nzp),
    .o_redirect   (redirect),
    .o_target     (target),
    .o_m_result   (m_result),
    .o_m_wdata    (m_wdata),
    .o_m_wsel     (m_wsel),
    .o_m_we       (m_we),
    .o_m_nzp_we   (m_nzp_we),
    .o_m_nzp      (m_nzp),
    .o_m_is_load  (m_is_load),
    .o_m_is_store (m_is_store)
  );

  lc4_memory u_memory (
    .gwe          (gwe),
    .i_rst_n      (i_rst_n),
    .i_m_result   (m_result),
    .i_m_wdata    (m_wdata),
    .i_m_wsel     (m_wsel),
    .i_m_we       (m_we),
    .i_m_nzp_we   (m_nzp_we),
    .i_m_nzp      (m_nzp),
    .i_m_is_load  (m_is_load),
    .i_m_is_store (m_is_store),
    .i_dmem_rdata (i_dmem_rdata),
    .o_dmem_addr  (o_dmem_addr),
    .o_dmem_we    (o_dmem_we),
    .o_dmem_wdata (o_dmem_wdata),
    .o_w_we       (w_we),
    .o_w_sel      (w_sel),
    .o_w_data     (w_data),
    .o_w_nzp_we   (w_nzp_we),
    .o_w_nzp      (w_nzp),
    .o_nzp        (nzp)
  );

endmodule

// File: bench/lc4_core_assertions.sv
module lc4_core_assertions #(
  parameter lc4_pipe_pkg::word_t P_RESET_PC = 16'h8200
) (
  input logic                gwe,
  input logic                i_rst_n,
  input lc4_pipe_pkg::word_t i_imem_addr,
  input lc4_pipe_pkg::word_t i_dmem_addr,
  input logic                i_dmem_we,
  input lc4_pipe_pkg::word_t i_dmem_wdata
);
  timeunit 1ns;
  timeprecision 1ps;
  import lc4_pipe_pkg::*;

  int err_count = 0; // Read by the testbench

  // Nothing reaches data memory while reset is held
  a_reset_quiet: assert property (@(posedge gwe) !i_rst_n |-> !i_dmem_we)
    else begin
      err_count++;
      $error("Error o_dmem_we %h while reset is held", $sampled(i_dmem_we));
    end

  // Pipeline still full of NOPs for three cycles after release
  a_fill_quiet: assert property (@(posedge gwe) i_rst_n && !$past(i_rst_n, 3) |-> !i_dmem_we)
    else begin
      err_count++;
      $error("Error o_dmem_we %h within three cycles of reset release", $sampled(i_dmem_we));
    end

  a_reset_pc: assert property (@(posedge gwe) $rose(i_rst_n) |-> i_imem_addr == P_RESET_PC)
    else begin
      err_count++;
      $error("Error o_imem_addr %h expected %h", $sampled(i_imem_addr), P_RESET_PC);
    end

  // Every legal store writes its own address minus one
  a_store_rule: assert property (@(posedge gwe) disable iff (!i_rst_n)
    i_dmem_we |-> i_dmem_wdata == i_dmem_addr - 16'd1)
    else begin
      err_count++;
      $error("Error o_dmem_wdata %h expected %h at o_dmem_addr %h",
             $sampled(i_dmem_wdata), $sampled(i_dmem_addr) - 16'd1, $sampled(i_dmem_addr));
    end

endmodule

bind lc4_core lc4_core_assertions #(.P_RESET_PC(P_RESET_PC)) u_checker (
  .gwe          (gwe),
  .i_rst_n      (i_rst_n),
  .i_imem_addr  (o_imem_addr),
  .i_dmem_addr  (o_dmem_addr),
  .i_dmem_we    (o_dmem_we),
  .i_dmem_wdata (o_dmem_wdata)
);

// File: bench/lc4_core_tb.sv
module lc4_core_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import lc4_isa_pkg::*;
  import lc4_pipe_pkg::*;

  localparam word_t RESET_PC   = 16'h3000;
  localparam int    NUM_TESTS  = 5;
  localparam word_t MARK_BASE  = 16'h7F00; // Marker n lands at MARK_BASE + n
  localparam int    RST_CYCLES = 10;

  logic  gwe;
  logic  i_rst_n;
  word_t o_imem_addr;
  insn_t i_imem_data;
  word_t o_dmem_addr;
  logic  o_dmem_we;
  word_t o_dmem_wdata;
  word_t i_dmem_rdata;

  insn_t       imem [65536];
  word_t       dmem [65536];
  word_t       pc_w;                  // Next free program slot
  logic [31:0] lfsr = 32'h3f94;
  int          cycles = 0;            // Since reset release
  int          cycle_limit;
  int          tests_done = 0;
  int          tests_failed = 0;
  int          order_errors = 0;
  int          errs_seen = 0;         // Assertion count at the last marker

  lc4_core #(.P_RESET_PC(RESET_PC)) u_dut (
    .gwe          (gwe),
    .i_rst_n      (i_rst_n),
    .o_imem_addr  (o_imem_addr),
    .i_imem_data  (i_imem_data),
    .o_dmem_addr  (o_dmem_addr),
    .o_dmem_we    (o_dmem_we),
    .o_dmem_wdata (o_dmem_wdata),
    .i_dmem_rdata (i_dmem_rdata)
  );

  // Both memories answer in the same cycle
  assign i_imem_data  = imem[o_imem_addr];
  assign i_dmem_rdata = dmem[o_dmem_addr];

  initial begin
    gwe = 1'b0;
    forever #50 gwe = ~gwe;
  end

  initial begin
    for (int k = 0; k < 65536; k++) begin
      dmem[word_t'(k)] <= word_t'(k - 1); // Word k holds k minus 1
    end
    forever begin
      @(posedge gwe);
      if (o_dmem_we) begin
        dmem[o_dmem_addr] <= o_dmem_wdata;
      end
    end
  end

  // Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One step per bit with the first bit ending up in the MSB
  function automatic int take_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = (v << 1) | int'(lfsr[0]);
    end
    return v;
  endfunction

  function automatic int signed_bits(input int n);
    int v;
    v = take_bits(n);
    return (v >= (1 << (n - 1))) ? v - (1 << n) : v;
  endfunction

  // Encoders straight from the field layout
  function automatic insn_t const_insn(input int rd, input int imm);
    return {OP_CONST, 3'(rd), 9'(imm)};
  endfunction

  function automatic insn_t reg_insn(input opcode_t op, input logic [2:0] sub,
                                     input int rd, input int rs, input int rt);
    return {op, 3'(rd), 3'(rs), sub, 3'(rt)};
  endfunction

  function automatic insn_t addi_insn(input int rd, input int rs, input int imm);
    return {OP_ARITH, 3'(rd), 3'(rs), 1'b1, 5'(imm)};
  endfunction

  function automatic insn_t ldr_insn(input int rd, input int rs, input int imm);
    return {OP_LDR, 3'(rd), 3'(rs), 6'(imm)};
  endfunction

  function automatic insn_t str_insn(input int rt, input int rs, input int imm);
    return {OP_STR, 3'(rt), 3'(rs), 6'(imm)};
  endfunction

  function automatic insn_t br_insn(input logic [2:0] nzp, input int off);
    return {OP_BR, nzp, 9'(off)};
  endfunction

  function automatic string test_title(input int num);
    case (num)
      1:       return "reset and marker base";
      2:       return "alu ops";
      3:       return "bypass distance";
      4:       return "load then store";
      default: return "branch and squash";
    endcase
  endfunction

  task automatic emit(input insn_t w);
    imem[pc_w] = w;
    pc_w = pc_w + 16'd1;
  endtask

  // Address is expected + 1, so the store rule holds only if rd == expected
  task automatic store_checked(input int rd, input int expected);
    emit(const_insn(7, expected + 1));
    emit(str_insn(rd, 7, 0));
  endtask

  task automatic add_marker(input int num);
    emit(addi_insn(5, 6, num - 1)); // R5 = marker address minus one
    emit(str_insn(5, 6, num));
  endtask

  task automatic alu_program();
    int a;
    int b;
    int k;
    for (int r = 0; r < 2; r++) begin
      a = signed_bits(7);
      b = signed_bits(7);
      k = signed_bits(5);
      emit(const_insn(0, a));
      emit(const_insn(1, b));
      emit(reg_insn(OP_ARITH, SUB_ADD, 2, 0, 1));
      store_checked(2, a + b);
      emit(reg_insn(OP_ARITH, SUB_SUB, 2, 0, 1));
      store_checked(2, a - b);
      emit(reg_insn(OP_LOGIC, 3'b000, 2, 0, 1));
      store_checked(2, a & b); // Sign-extended inputs keep the AND in range
      emit(addi_insn(2, 0, k));
      store_checked(2, a + k);
    end
    add_marker(2);
  endtask

  task automatic bypass_program();
    int b;
    int k;
    int cur; // Expected R2
    b = signed_bits(7);
    cur = signed_bits(7);
    emit(const_insn(1, b));
    emit(const_insn(2, cur));
    for (int d = 1; d <= 4; d++) begin
      k = signed_bits(5);
      if (k == 0) begin
        k = 1; // Producer must change R2 or a stale read goes unseen
      end
      cur = cur + k;
      emit(addi_insn(2, 2, k));
      for (int f = 1; f < d; f++) begin
        emit(const_insn(4, f)); // Independent filler
      end
      if (d % 2 == 1) begin
        emit(reg_insn(OP_ARITH, SUB_ADD, 3, 2, 1)); // Producer on rs
      end else begin
        emit(reg_insn(OP_ARITH, SUB_ADD, 3, 1, 2)); // Producer on rt
      end
      store_checked(3, cur + b);
    end
    add_marker(3);
  endtask

  task automatic load_program();
    int base;
    int off;
    for (int r = 0; r < 2; r++) begin
      base = take_bits(7);
      off  = take_bits(4);
      emit(const_insn(7, base));
      emit(ldr_insn(3, 7, off));
      emit(const_insn(4, r));         // Keeps the load-use gap
      emit(str_insn(3, 7, off));      // Loaded word back to its own address
      emit(ldr_insn(2, 7, off + 1));
      emit(const_insn(4, r));
      emit(addi_insn(2, 2, 1));
      store_checked(2, base + off + 1);
    end
    add_marker(4);
  endtask

  task automatic branch_program();
    int          v;
    logic [2:0]  match;
    for (int c = 0; c < 3; c++) begin
      v = take_bits(6) + 1;
      if (c == 0) begin
        v = -v;
      end else if (c == 1) begin
        v = 0;
      end
      match = 3'b100 >> c;             // N, then Z, then P
      emit(const_insn(0, v));
      emit(br_insn(match, 2));
      emit(str_insn(6, 6, -1));        // Off-rule store that must be squashed
      emit(str_insn(6, 6, -1));
      store_checked(0, v);
      emit(const_insn(0, v));
      emit(br_insn(~match, 3));        // Wrongly taken lands on the bad store
      store_checked(0, v);
      emit(br_insn(3'b111, 1));
      emit(str_insn(6, 6, -1));
    end
    add_marker(5);
  endtask

  task automatic write_program();
    for (int k = 0; k < 65536; k++) begin
      imem[word_t'(k)] = NOP_INSN;
    end
    pc_w = RESET_PC;
    emit(const_insn(6, 127));
    repeat (8) emit(reg_insn(OP_ARITH, SUB_ADD, 6, 6, 6)); // R6 = 16'h7F00
    add_marker(1);
    alu_program();
    bypass_program();
    load_program();
    branch_program();
  endtask

  task automatic finish_test(input int num);
    int errs;
    errs = u_dut.u_checker.err_count;
    if (num != tests_done + 1 || num > NUM_TESTS) begin
      order_errors++;
      $display("Marker for test %0d arrived out of order after test %0d", num, tests_done);
    end else begin
      if (errs == errs_seen) begin
        $display("Test %0d %s: passed", num, test_title(num));
      end else begin
        tests_failed++;
        $display("Test %0d %s: failed with %0d assertion errors", num, test_title(num),
                 errs - errs_seen);
      end
      errs_seen = errs;
      tests_done++;
    end
  endtask

  always @(posedge gwe) begin
    if (i_rst_n) begin
      cycles <= cycles + 1;
    end
  end

  // Mid-cycle look at the store port for markers
  always @(negedge gwe) begin
    if (o_dmem_we && o_dmem_addr[15:4] == MARK_BASE[15:4]) begin
      finish_test(int'(o_dmem_addr[3:0]));
    end
  end

  initial begin
    i_rst_n <= 1'b0;
    write_program();
    cycle_limit = 2 * int'(pc_w - RESET_PC) + 20 * NUM_TESTS;
    repeat (RST_CYCLES) @(posedge gwe);
    i_rst_n <= 1'b1;
    while (tests_done < NUM_TESTS && cycles < cycle_limit) begin
      @(posedge gwe);
    end
    @(negedge gwe); // Check of the last marker store has settled by now
    if (tests_done < NUM_TESTS) begin
      $display("Timeout: only %0d of %0d tests finished within %0d cycles",
               tests_done, NUM_TESTS, cycle_limit);
    end
    $display("Tests passed %0d, failed %0d, missing %0d, assertion errors %0d",
             tests_done - tests_failed, tests_failed, NUM_TESTS - tests_done,
             u_dut.u_checker.err_count);
    if (tests_done == NUM_TESTS && tests_failed == 0 && order_errors == 0 &&
        u_dut.u_checker.err_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: lc4_core.f
logic/lc4_isa_pkg.sv
logic/lc4_pipe_pkg.sv
logic/lc4_fetch.sv
logic/lc4_regfile.sv
logic/lc4_decode.sv
logic/lc4_execute.sv
logic/lc4_memory.sv
logic/lc4_core.sv
bench/lc4_core_assertions.sv
bench/lc4_core_tb.sv

// File: Makefile
TOP := lc4_core_tb
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f lc4_core.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f lc4_core.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) +verilator+error+limit+100 > $(LOG) 2>&1; cat $(LOG)
	grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
